/* design/dualIssue_defines.svh */
// Sizing macros shared by the core and its packages
// DATA_WIDTH is assumed to be 32 (RV32I immediates are built for a 32-bit word)
`ifndef DUALISSUE_DEFINES_SVH
`define DUALISSUE_DEFINES_SVH

// Register and result word
`define DATA_WIDTH 32

// Architectural register file
`define REG_COUNT 32
`define REG_IDX_W 5

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* design/isaPkg.sv */
// RV32I encodings for the subset run by the core
// Only LUI, OP-IMM and OP opcodes are decoded, everything else is a nop
`default_nettype none

package isaPkg;

    // Major opcodes handled by the lanes
    typedef enum logic [6:0] {
        OPC_LUI   = 7'b0110111,
        OPC_OPIMM = 7'b0010011,
        OPC_OP    = 7'b0110011
    } opcodeE;

    // funct3 values shared by OP-IMM and OP
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // Instruction bit 30 (funct7[5]) turns ADD into SUB for OP
    localparam int FUNCT7_SUB_BIT = 30;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOpE;

    // Immediate format, I for OP-IMM and U for LUI
    typedef enum logic {
        IMM_I,
        IMM_U
    } immKindE;

endpackage

`default_nettype wire

/* design/pipePkg.sv */
// Pipeline-side types shared by the lanes and the register file
`default_nettype none
`include "dualIssue_defines.svh"

package pipePkg;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        SRC_RF,
        SRC_OWN_WB,
        SRC_OTHER_WB
    } srcSelE;

    // Writeback stage contents, also used as a register file write port
    // write is only ever set together with valid
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`DATA_WIDTH-1:0] data;
    } stageRecT;

endpackage

`default_nettype wire

/* design/pairIssue.sv */
// Accepts a pair when instrValid_i and ready_o are high at a rising edge
// A same-pair RAW or WAW splits the pair, slot 2 then issues one cycle later
`timescale 1ns/100ps
`default_nettype none
`include "dualIssue_defines.svh"

module pairIssue (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instrValid_i,
    input  logic [31:0]           instr1_i,
    input  logic [31:0]           instr2_i,
    output logic                  ready_o,
    output logic                  lane1Issue_o,
    output logic                  lane1Write_o,
    output logic [31:0]           lane1Instr_o,
    output logic                  lane2Issue_o,
    output logic                  lane2Write_o,
    output logic [31:0]           lane2Instr_o,
    output logic [`REG_IDX_W-1:0] rs1Lane1_o,
    output logic [`REG_IDX_W-1:0] rs2Lane1_o,
    output logic [`REG_IDX_W-1:0] rs1Lane2_o,
    output logic [`REG_IDX_W-1:0] rs2Lane2_o
);

    function automatic logic writesRd(input logic [31:0] instr);
        writesRd = (instr[6:0] == isaPkg::OPC_LUI) ||
                   (instr[6:0] == isaPkg::OPC_OPIMM) ||
                   (instr[6:0] == isaPkg::OPC_OP);
    endfunction

    // LUI reads nothing, OP-IMM reads rs1, OP reads both sources
    function automatic logic readsReg(input logic [31:0] instr,
                                      input logic [`REG_IDX_W-1:0] idx);
        logic usesRs1;
        logic usesRs2;
        usesRs1 = (instr[6:0] == isaPkg::OPC_OPIMM) || (instr[6:0] == isaPkg::OPC_OP);
        usesRs2 = (instr[6:0] == isaPkg::OPC_OP);
        readsReg = (usesRs1 && instr[19:15] == idx) || (usesRs2 && instr[24:20] == idx);
    endfunction

    logic                  holdValid;
    logic [31:0]           heldInstr;
    logic                  accept;
    logic [`REG_IDX_W-1:0] rd1;
    logic [`REG_IDX_W-1:0] rd2;
    logic                  slot1Writes;
    logic                  rawHazard;
    logic                  wawHazard;
    logic                  split;

    assign ready_o = !holdValid;
    assign accept  = instrValid_i && ready_o;

    assign rd1         = instr1_i[11:7];
    assign rd2         = instr2_i[11:7];
    assign slot1Writes = writesRd(instr1_i) && (rd1 != '0);
    assign rawHazard   = slot1Writes && readsReg(instr2_i, rd1);
    assign wawHazard   = slot1Writes && writesRd(instr2_i) && (rd2 == rd1);
    assign split       = accept && (rawHazard || wawHazard);

    // Slot 1 always goes to lane 1
    assign lane1Issue_o = accept;
    assign lane1Instr_o = instr1_i;
    assign lane1Write_o = accept && writesRd(instr1_i);

    // Lane 2 takes the held slot while one is pending
    assign lane2Instr_o = holdValid ? heldInstr : instr2_i;
    assign lane2Issue_o = holdValid || (accept && !(rawHazard || wawHazard));
    assign lane2Write_o = lane2Issue_o && writesRd(lane2Instr_o);

    assign rs1Lane1_o = lane1Instr_o[19:15];
    assign rs2Lane1_o = lane1Instr_o[24:20];
    assign rs1Lane2_o = lane2Instr_o[19:15];
    assign rs2Lane2_o = lane2Instr_o[24:20];

    // Hold lasts exactly one cycle since no accept happens while it is set
    always_ff @(posedge clk) begin
        if (reset) begin
            holdValid <= 1'b0;
        end else begin
            holdValid <= split;
        end
    end

    always_ff @(posedge clk) begin
        heldInstr <= split ? instr2_i : `NOP_INSTR;
    end

    aNoPairRaw: assert property (
        @(posedge clk) disable iff (reset)
        (lane1Issue_o && lane2Issue_o && lane1Write_o && lane1Instr_o[11:7] != '0)
            |-> !readsReg(lane2Instr_o, lane1Instr_o[11:7])
    ) else $error("pairIssue: unsplit pair has lane 2 reading lane 1 rd");

endmodule

`default_nettype wire

/* design/regFile.sv */
// 32 x DATA_WIDTH register file, four combinational reads and two write ports
// Reads see same-cycle write data, x0 reads as zero
`timescale 1ns/100ps
`default_nettype none
`include "dualIssue_defines.svh"

module regFile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_IDX_W-1:0]  rs1Lane1_i,
    input  logic [`REG_IDX_W-1:0]  rs2Lane1_i,
    input  logic [`REG_IDX_W-1:0]  rs1Lane2_i,
    input  logic [`REG_IDX_W-1:0]  rs2Lane2_i,
    output logic [`DATA_WIDTH-1:0] rd1Lane1_o,
    output logic [`DATA_WIDTH-1:0] rd2Lane1_o,
    output logic [`DATA_WIDTH-1:0] rd1Lane2_o,
    output logic [`DATA_WIDTH-1:0] rd2Lane2_o,
    input  pipePkg::stageRecT      wrLane1_i,
    input  pipePkg::stageRecT      wrLane2_i
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    function automatic logic portWrites(input pipePkg::stageRecT wr);
        portWrites = wr.valid && wr.write && (wr.rd != '0);
    endfunction

    // Write-through bypass ahead of the stored value
    function automatic logic [`DATA_WIDTH-1:0] readPort(
        input logic [`REG_IDX_W-1:0]  addr,
        input logic [`DATA_WIDTH-1:0] stored,
        input pipePkg::stageRecT      wr1,
        input pipePkg::stageRecT      wr2
    );
        if (addr == '0) begin
            readPort = '0;
        end else if (portWrites(wr2) && wr2.rd == addr) begin
            readPort = wr2.data;
        end else if (portWrites(wr1) && wr1.rd == addr) begin
            readPort = wr1.data;
        end else begin
            readPort = stored;
        end
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (portWrites(wrLane1_i)) begin
                regs[wrLane1_i.rd] <= wrLane1_i.data;
            end
            if (portWrites(wrLane2_i)) begin
                regs[wrLane2_i.rd] <= wrLane2_i.data;
            end
        end
    end

    assign rd1Lane1_o = readPort(rs1Lane1_i, regs[rs1Lane1_i], wrLane1_i, wrLane2_i);
    assign rd2Lane1_o = readPort(rs2Lane1_i, regs[rs2Lane1_i], wrLane1_i, wrLane2_i);
    assign rd1Lane2_o = readPort(rs1Lane2_i, regs[rs1Lane2_i], wrLane1_i, wrLane2_i);
    assign rd2Lane2_o = readPort(rs2Lane2_i, regs[rs2Lane2_i], wrLane1_i, wrLane2_i);

    // Pair splitting upstream keeps the two lanes off the same register
    aNoDualWrite: assert property (
        @(posedge clk) disable iff (reset)
        !(portWrites(wrLane1_i) && portWrites(wrLane2_i) && wrLane1_i.rd == wrLane2_i.rd)
    ) else $error("regFile: both write ports target x%0d", wrLane1_i.rd);

endmodule

`default_nettype wire

/* design/execLane.sv */
// One execute lane with an execute stage captured at issue and a writeback stage one edge later
// Operands forward from this lane's and the other lane's writeback record
`timescale 1ns/100ps
`default_nettype none
`include "dualIssue_defines.svh"

module execLane (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   issue_i,
    input  logic                   write_i,
    input  logic [31:0]            instr_i,
    input  logic [`DATA_WIDTH-1:0] rs1Data_i,
    input  logic [`DATA_WIDTH-1:0] rs2Data_i,
    input  pipePkg::stageRecT      otherWb_i,
    output pipePkg::stageRecT      wb_o
);

    function automatic logic matchesRec(input pipePkg::stageRecT rec,
                                        input logic [`REG_IDX_W-1:0] idx);
        matchesRec = rec.valid && rec.write && (rec.rd != '0) && (rec.rd == idx);
    endfunction

    // Own lane first, both can never match at once
    function automatic pipePkg::srcSelE pickSrc(input logic [`REG_IDX_W-1:0] idx,
                                                input pipePkg::stageRecT own,
                                                input pipePkg::stageRecT other);
        if (matchesRec(own, idx)) begin
            pickSrc = pipePkg::SRC_OWN_WB;
        end else if (matchesRec(other, idx)) begin
            pickSrc = pipePkg::SRC_OTHER_WB;
        end else begin
            pickSrc = pipePkg::SRC_RF;
        end
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] selData(input pipePkg::srcSelE sel,
                                                       input logic [`DATA_WIDTH-1:0] rfVal,
                                                       input pipePkg::stageRecT own,
                                                       input pipePkg::stageRecT other);
        case (sel)
            pipePkg::SRC_OWN_WB:   selData = own.data;
            pipePkg::SRC_OTHER_WB: selData = other.data;
            default:               selData = rfVal;
        endcase
    endfunction

    // OP-IMM and OP share the funct3 map, unknown funct3 falls back to add
    function automatic isaPkg::aluOpE f3Op(input logic [2:0] funct3);
        case (funct3)
            isaPkg::F3_XOR: f3Op = isaPkg::ALU_XOR;
            isaPkg::F3_OR:  f3Op = isaPkg::ALU_OR;
            isaPkg::F3_AND: f3Op = isaPkg::ALU_AND;
            default:        f3Op = isaPkg::ALU_ADD;
        endcase
    endfunction

    // Execute stage
    logic                   exValid;
    logic                   exWrite;
    logic [31:0]            exInstr;
    logic [`DATA_WIDTH-1:0] exRs1Data;
    logic [`DATA_WIDTH-1:0] exRs2Data;
    logic [`REG_IDX_W-1:0]  exRs1;
    logic [`REG_IDX_W-1:0]  exRs2;
    logic [`REG_IDX_W-1:0]  exRd;

    isaPkg::aluOpE          aluOp;
    isaPkg::immKindE        immKind;
    logic                   useImm;
    logic [`DATA_WIDTH-1:0] imm;
    pipePkg::srcSelE        srcASel;
    pipePkg::srcSelE        srcBSel;
    logic [`DATA_WIDTH-1:0] srcA;
    logic [`DATA_WIDTH-1:0] rs2Val;
    logic [`DATA_WIDTH-1:0] srcB;
    logic [`DATA_WIDTH-1:0] aluResult;

    // Writeback stage
    logic                   wbValid;
    logic                   wbWrite;
    logic [`REG_IDX_W-1:0]  wbRd;
    logic [`DATA_WIDTH-1:0] wbData;

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
            exWrite <= 1'b0;
        end else begin
            exValid <= issue_i;
            exWrite <= issue_i && write_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            exInstr   <= instr_i;
            exRs1Data <= rs1Data_i;
            exRs2Data <= rs2Data_i;
        end
    end

    assign exRs1 = exInstr[19:15];
    assign exRs2 = exInstr[24:20];
    assign exRd  = exInstr[11:7];

    always_comb begin
        aluOp   = isaPkg::ALU_ADD;
        immKind = isaPkg::IMM_I;
        useImm  = 1'b0;
        case (exInstr[6:0])
            isaPkg::OPC_LUI: begin
                aluOp   = isaPkg::ALU_PASSB;
                immKind = isaPkg::IMM_U;
                useImm  = 1'b1;
            end
            isaPkg::OPC_OPIMM: begin
                aluOp  = f3Op(exInstr[14:12]);
                useImm = 1'b1;
            end
            isaPkg::OPC_OP: begin
                if (exInstr[14:12] == isaPkg::F3_ADD && exInstr[isaPkg::FUNCT7_SUB_BIT]) begin
                    aluOp = isaPkg::ALU_SUB;
                end else begin
                    aluOp = f3Op(exInstr[14:12]);
                end
            end
            default: begin
                useImm = 1'b0;
            end
        endcase
    end

    assign imm = (immKind == isaPkg::IMM_U) ? {exInstr[31:12], 12'b0}
                                            : {{20{exInstr[31]}}, exInstr[31:20]};

    assign srcASel = pickSrc(exRs1, wb_o, otherWb_i);
    assign srcBSel = pickSrc(exRs2, wb_o, otherWb_i);
    assign srcA    = selData(srcASel, exRs1Data, wb_o, otherWb_i);
    assign rs2Val  = selData(srcBSel, exRs2Data, wb_o, otherWb_i);
    assign srcB    = useImm ? imm : rs2Val;

    always_comb begin
        case (aluOp)
            isaPkg::ALU_SUB:   aluResult = srcA - srcB;
            isaPkg::ALU_XOR:   aluResult = srcA ^ srcB;
            isaPkg::ALU_OR:    aluResult = srcA | srcB;
            isaPkg::ALU_AND:   aluResult = srcA & srcB;
            isaPkg::ALU_PASSB: aluResult = srcB;
            default:           aluResult = srcA + srcB;
        endcase
    end

    // x0 destinations drop their write here
    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid <= 1'b0;
            wbWrite <= 1'b0;
        end else begin
            wbValid <= exValid;
            wbWrite <= exWrite && (exRd != '0);
        end
    end

    always_ff @(posedge clk) begin
        wbRd   <= exRd;
        wbData <= aluResult;
    end

    assign wb_o = '{valid: wbValid, write: wbWrite, rd: wbRd, data: wbData};

    aSingleForward: assert property (
        @(posedge clk) disable iff (reset)
        exValid |-> !(matchesRec(wb_o, exRs1) && matchesRec(otherWb_i, exRs1)) &&
                    !(matchesRec(wb_o, exRs2) && matchesRec(otherWb_i, exRs2))
    ) else $error("execLane: operand matches both writeback records");

endmodule

`default_nettype wire

/* design/dualIssueCore.sv */
// Dual-issue RV32I execute core, no fetch, branches or memory stage
// Retire outputs have no back-pressure and show writes to nonzero rd only
`timescale 1ns/100ps
`default_nettype none
`include "dualIssue_defines.svh"

module dualIssueCore (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   instrValid_i,
    input  logic [31:0]            instr1_i,
    input  logic [31:0]            instr2_i,
    output logic                   ready_o,
    output logic                   retire1Valid_o,
    output logic [`REG_IDX_W-1:0]  retire1Rd_o,
    output logic [`DATA_WIDTH-1:0] retire1Data_o,
    output logic                   retire2Valid_o,
    output logic [`REG_IDX_W-1:0]  retire2Rd_o,
    output logic [`DATA_WIDTH-1:0] retire2Data_o
);

    logic                   lane1Issue;
    logic                   lane1Write;
    logic [31:0]            lane1Instr;
    logic                   lane2Issue;
    logic                   lane2Write;
    logic [31:0]            lane2Instr;
    logic [`REG_IDX_W-1:0]  rs1Lane1;
    logic [`REG_IDX_W-1:0]  rs2Lane1;
    logic [`REG_IDX_W-1:0]  rs1Lane2;
    logic [`REG_IDX_W-1:0]  rs2Lane2;
    logic [`DATA_WIDTH-1:0] rd1Lane1;
    logic [`DATA_WIDTH-1:0] rd2Lane1;
    logic [`DATA_WIDTH-1:0] rd1Lane2;
    logic [`DATA_WIDTH-1:0] rd2Lane2;
    pipePkg::stageRecT      wb1;
    pipePkg::stageRecT      wb2;

    pairIssue issueUnit (
        .clk          (clk),
        .reset        (reset),
        .instrValid_i (instrValid_i),
        .instr1_i     (instr1_i),
        .instr2_i     (instr2_i),
        .ready_o      (ready_o),
        .lane1Issue_o (lane1Issue),
        .lane1Write_o (lane1Write),
        .lane1Instr_o (lane1Instr),
        .lane2Issue_o (lane2Issue),
        .lane2Write_o (lane2Write),
        .lane2Instr_o (lane2Instr),
        .rs1Lane1_o   (rs1Lane1),
        .rs2Lane1_o   (rs2Lane1),
        .rs1Lane2_o   (rs1Lane2),
        .rs2Lane2_o   (rs2Lane2)
    );

    regFile regs (
        .clk        (clk),
        .reset      (reset),
        .rs1Lane1_i (rs1Lane1),
        .rs2Lane1_i (rs2Lane1),
        .rs1Lane2_i (rs1Lane2),
        .rs2Lane2_i (rs2Lane2),
        .rd1Lane1_o (rd1Lane1),
        .rd2Lane1_o (rd2Lane1),
        .rd1Lane2_o (rd1Lane2),
        .rd2Lane2_o (rd2Lane2),
        .wrLane1_i  (wb1),
        .wrLane2_i  (wb2)
    );

    execLane lane1 (
        .clk       (clk),
        .reset     (reset),
        .issue_i   (lane1Issue),
        .write_i   (lane1Write),
        .instr_i   (lane1Instr),
        .rs1Data_i (rd1Lane1),
        .rs2Data_i (rd2Lane1),
        .otherWb_i (wb2),
        .wb_o      (wb1)
    );

    execLane lane2 (
        .clk       (clk),
        .reset     (reset),
        .issue_i   (lane2Issue),
        .write_i   (lane2Write),
        .instr_i   (lane2Instr),
        .rs1Data_i (rd1Lane2),
        .rs2Data_i (rd2Lane2),
        .otherWb_i (wb1),
        .wb_o      (wb2)
    );

    // A record's write bit already covers valid and a nonzero rd
    assign retire1Valid_o = wb1.write;
    assign retire1Rd_o    = wb1.rd;
    assign retire1Data_o  = wb1.data;
    assign retire2Valid_o = wb2.write;
    assign retire2Rd_o    = wb2.rd;
    assign retire2Data_o  = wb2.data;

endmodule

`default_nettype wire

/* test/coreTb.sv */
// Random pair stream over x0..x7 against an in-order reference model of the core
// Retirement is expected two edges after issue, a split slot 2 one edge later
`timescale 1ns/100ps
`default_nettype none
`include "dualIssue_defines.svh"

module coreTb;

    localparam int NUM_PAIRS   = 400;
    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 1;

    logic                   clk;
    logic                   reset;
    logic                   instrValid_i;
    logic [31:0]            instr1_i;
    logic [31:0]            instr2_i;
    logic                   ready_o;
    logic                   retire1Valid_o;
    logic [`REG_IDX_W-1:0]  retire1Rd_o;
    logic [`DATA_WIDTH-1:0] retire1Data_o;
    logic                   retire2Valid_o;
    logic [`REG_IDX_W-1:0]  retire2Rd_o;
    logic [`DATA_WIDTH-1:0] retire2Data_o;

    // Reference state
    logic [`DATA_WIDTH-1:0] model [`REG_COUNT];
    int                     due1Q [$];
    logic [`REG_IDX_W-1:0]  rd1Q [$];
    logic [`DATA_WIDTH-1:0] data1Q [$];
    int                     due2Q [$];
    logic [`REG_IDX_W-1:0]  rd2Q [$];
    logic [`DATA_WIDTH-1:0] data2Q [$];
    int                     cyc;
    int                     pairsDone;
    logic                   expReady;
    logic                   pending;
    logic [31:0]            heldInstr;
    logic                   took;

    dualIssueCore dut_i (
        .clk            (clk),
        .reset          (reset),
        .instrValid_i   (instrValid_i),
        .instr1_i       (instr1_i),
        .instr2_i       (instr2_i),
        .ready_o        (ready_o),
        .retire1Valid_o (retire1Valid_o),
        .retire1Rd_o    (retire1Rd_o),
        .retire1Data_o  (retire1Data_o),
        .retire2Valid_o (retire2Valid_o),
        .retire2Rd_o    (retire2Rd_o),
        .retire2Data_o  (retire2Data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic mismatch(input string what);
        $display("ERR %0t: %s", $time, what);
        $display("sim failed");
        $fatal;
    endtask

    function automatic logic [2:0] funct3For(input int k);
        case (k)
            1:       funct3For = 3'b100;
            2:       funct3For = 3'b110;
            3:       funct3For = 3'b111;
            default: funct3For = 3'b000;
        endcase
    endfunction

    // Supported mix plus a load opcode that must behave as a nop
    function automatic logic [31:0] makeInstr();
        int unsigned       pick;
        logic [31:0]       r;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        pick = $urandom_range(0, 11);
        r    = $urandom();
        rd   = {2'b00, r[2:0]};
        rs1  = {2'b00, r[5:3]};
        rs2  = {2'b00, r[8:6]};
        case (pick)
            0:       makeInstr = {r[31:12], rd, isaPkg::OPC_LUI};
            1, 2, 3, 4:
                makeInstr = {r[31:20], rs1, funct3For(pick - 1), rd, isaPkg::OPC_OPIMM};
            5, 6, 7, 8:
                makeInstr = {7'b0, rs2, rs1, funct3For(pick - 5), rd, isaPkg::OPC_OP};
            9:       makeInstr = {7'b0100000, rs2, rs1, 3'b000, rd, isaPkg::OPC_OP};
            default: makeInstr = {r[31:12], rd, 7'b0000011};
        endcase
    endfunction

    // Writes a nonzero rd
    function automatic logic hasDest(input logic [31:0] ins);
        hasDest = (ins[6:0] == isaPkg::OPC_LUI || ins[6:0] == isaPkg::OPC_OPIMM ||
                   ins[6:0] == isaPkg::OPC_OP) && ins[11:7] != 5'd0;
    endfunction

    function automatic logic usesReg(input logic [31:0] ins, input logic [4:0] r);
        logic src1;
        logic src2;
        src1 = (ins[6:0] == isaPkg::OPC_OPIMM || ins[6:0] == isaPkg::OPC_OP) &&
               ins[19:15] == r;
        src2 = (ins[6:0] == isaPkg::OPC_OP) && ins[24:20] == r;
        usesReg = src1 || src2;
    endfunction

    function automatic logic splits(input logic [31:0] i1, input logic [31:0] i2);
        splits = hasDest(i1) &&
                 (usesReg(i2, i1[11:7]) || (hasDest(i2) && i2[11:7] == i1[11:7]));
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] evalInstr(input logic [31:0] ins);
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] immI;
        a    = model[ins[19:15]];
        b    = model[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        evalInstr = '0;
        if (ins[6:0] == isaPkg::OPC_LUI) begin
            evalInstr = {ins[31:12], 12'h000};
        end else if (ins[6:0] == isaPkg::OPC_OPIMM) begin
            case (ins[14:12])
                3'b100:  evalInstr = a ^ immI;
                3'b110:  evalInstr = a | immI;
                3'b111:  evalInstr = a & immI;
                default: evalInstr = a + immI;
            endcase
        end else if (ins[6:0] == isaPkg::OPC_OP) begin
            case (ins[14:12])
                3'b100:  evalInstr = a ^ b;
                3'b110:  evalInstr = a | b;
                3'b111:  evalInstr = a & b;
                default: evalInstr = ins[30] ? a - b : a + b;
            endcase
        end
    endfunction

    // Executes in program order and books the retirement on its lane
    task automatic issueModel(input int lane, input logic [31:0] ins, input int due);
        logic [`DATA_WIDTH-1:0] val;
        val = evalInstr(ins);
        if (hasDest(ins)) begin
            model[ins[11:7]] = val;
            if (lane == 1) begin
                due1Q.push_back(due);
                rd1Q.push_back(ins[11:7]);
                data1Q.push_back(val);
            end else begin
                due2Q.push_back(due);
                rd2Q.push_back(ins[11:7]);
                data2Q.push_back(val);
            end
        end
    endtask

    task automatic expectLane(input int lane, input logic actV, input logic [4:0] actRd,
                              input logic [`DATA_WIDTH-1:0] actData);
        logic                   expV;
        logic [4:0]             expRd;
        logic [`DATA_WIDTH-1:0] expData;
        expV    = 1'b0;
        expRd   = '0;
        expData = '0;
        if (lane == 1 && due1Q.size() > 0 && due1Q[0] == cyc) begin
            expV    = 1'b1;
            expRd   = rd1Q.pop_front();
            expData = data1Q.pop_front();
            void'(due1Q.pop_front());
        end else if (lane == 2 && due2Q.size() > 0 && due2Q[0] == cyc) begin
            expV    = 1'b1;
            expRd   = rd2Q.pop_front();
            expData = data2Q.pop_front();
            void'(due2Q.pop_front());
        end
        assert (actV === expV)
            else mismatch($sformatf("lane %0d retire valid %b, expected %b", lane, actV, expV));
        if (expV) begin
            assert (actRd === expRd && actData === expData)
                else mismatch($sformatf("lane %0d retired x%0d=%h, expected x%0d=%h",
                                        lane, actRd, actData, expRd, expData));
        end
    endtask

    initial begin
        void'($urandom(32'h266b));
        reset        = 1'b1;
        instrValid_i = 1'b0;
        instr1_i     = `NOP_INSTR;
        instr2_i     = `NOP_INSTR;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        cyc       = 0;
        pairsDone = 0;
        expReady  = 1'b1;
        pending   = 1'b0;
        heldInstr = `NOP_INSTR;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        while (pairsDone < NUM_PAIRS || pending || due1Q.size() > 0 || due2Q.size() > 0) begin
            @(negedge clk);
            assert (ready_o === expReady)
                else mismatch($sformatf("ready_o %b, expected %b", ready_o, expReady));
            expectLane(1, retire1Valid_o, retire1Rd_o, retire1Data_o);
            expectLane(2, retire2Valid_o, retire2Rd_o, retire2Data_o);
            @(posedge clk);
            cyc++;
            took = instrValid_i && expReady;
            if (pending) begin
                issueModel(2, heldInstr, cyc + 1);
                pending  = 1'b0;
                expReady = 1'b1;
            end
            if (took) begin
                issueModel(1, instr1_i, cyc + 1);
                if (splits(instr1_i, instr2_i)) begin
                    pending   = 1'b1;
                    heldInstr = instr2_i;
                    expReady  = 1'b0;
                end else begin
                    issueModel(2, instr2_i, cyc + 1);
                end
                pairsDone++;
            end
            #DRIVE_DELAY;
            if (pairsDone == NUM_PAIRS) begin
                instrValid_i = 1'b0;
            end else if (took || !instrValid_i) begin
                instrValid_i = ($urandom_range(0, 7) != 0);
                instr1_i     = makeInstr();
                instr2_i     = makeInstr();
            end
        end
        @(negedge clk);
        if (ready_o === 1'b1 && retire1Valid_o === 1'b0 && retire2Valid_o === 1'b0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("core still busy after the last expected retirement");
            $display("sim failed");
            $fatal;
        end
    end

    // Each accepted pair takes at most two cycles, idle cycles are rare
    initial begin
        repeat (NUM_PAIRS * 3 + 40) @(posedge clk);
        $display("watchdog expired before all pairs retired");
        $display("sim failed");
        $fatal;
    end

    readyOneCycle: assert property (
        @(posedge clk) disable iff (reset)
        !ready_o |=> ready_o
    ) else begin
        $display("ready_o stayed low for more than one cycle");
        $display("sim failed");
        $fatal;
    end

    retireRdNonzero: assert property (
        @(posedge clk) disable iff (reset)
        (retire1Valid_o |-> retire1Rd_o != '0) and (retire2Valid_o |-> retire2Rd_o != '0)
    ) else begin
        $display("a retire valid was raised for a write to x0");
        $display("sim failed");
        $fatal;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/pairIssue.sv
design/regFile.sv
design/execLane.sv
design/dualIssueCore.sv
test/coreTb.sv

/* run.sh */
#!/bin/sh
# Build and run coreTb with Verilator, the exit status reports pass or fail
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -f list.f --top-module coreTb -Mdir obj_dir \
    && ./obj_dir/VcoreTb \
    || exit 1
